/* logic/regf_settings.svh */
//////////////////////////////////////////////////
// I3C master register file settings
// Widths, array depth, fixed register locations
// and the reset value of every defaulted byte
//////////////////////////////////////////////////
`ifndef REGF_SETTINGS_SVH
`define REGF_SETTINGS_SVH

// Geometry
`define REGF_DATA_W          8        // One register byte
`define REGF_DEPTH           512      // Bytes in the array
`define REGF_ADDR_W          9        // Array address width
`define REGF_PADDR_W         12       // APB address width
`define REGF_DESC_BYTES      8        // Command descriptor size
`define REGF_HJ_BIT          3        // ENHJ / DISHJ position in the event bytes

// Fixed register locations
`define REGF_ADDR_TGT        0        // Target address, bit 0 is RnW
`define REGF_ADDR_NUM_FRAMES 1
`define REGF_ADDR_TX_DATA    2        // First of three default data bytes
`define REGF_ADDR_BCAST_WR   46       // 7'h7E + W
`define REGF_ADDR_BCAST_RD   47       // 7'h7E + R
`define REGF_ADDR_ARB        48       // Arbitration address
`define REGF_ADDR_ENTDAA     49
`define REGF_ADDR_IBI_CFG    101
`define REGF_ADDR_PAYLOAD    102      // IBI payload max size
`define REGF_ADDR_DISEC_DIR  103      // DISEC direct CCC
`define REGF_ADDR_DISEC_BC   104      // DISEC broadcast CCC
`define REGF_ADDR_EVT_DIS    392      // Disable target events byte
`define REGF_ADDR_ENEC_CCC   401
`define REGF_ADDR_ENEC_BYTE  402
`define REGF_ADDR_DISEC_CCC  403
`define REGF_ADDR_DISEC_BYTE 404
`define REGF_ADDR_HJ_CFG     405
`define REGF_ADDR_CRCAP1     409
`define REGF_ADDR_DUMMY_DESC 450      // Fixed dummy command descriptor

// Reset values
`define REGF_RST_TGT         8'hA8
`define REGF_RST_NUM_FRAMES  8'h02
`define REGF_RST_TX_DATA0    8'h01
`define REGF_RST_TX_DATA1    8'h02
`define REGF_RST_TX_DATA2    8'h06
`define REGF_RST_BCAST_WR    8'hFC
`define REGF_RST_BCAST_RD    8'hFD
`define REGF_RST_ARB         8'h53
`define REGF_RST_ENTDAA      8'h07
`define REGF_RST_IBI_CFG     8'h01    // ACK with MDB only
`define REGF_RST_PAYLOAD     8'h03
`define REGF_RST_DISEC_DIR   8'h81
`define REGF_RST_DISEC_BC    8'h01
`define REGF_RST_EVT_DIS     8'h0B
`define REGF_RST_ENEC_CCC    8'h00
`define REGF_RST_ENEC_BYTE   8'h0B    // ENINT, ENCR, ENHJ
`define REGF_RST_DISEC_CCC   8'h01
`define REGF_RST_DISEC_BYTE  8'h00
`define REGF_RST_HJ_CFG      8'h07
`define REGF_RST_CRCAP1      8'h00
`define REGF_RST_DUMMY_DESC  64'h0000_0000_1800_8F81  // Byte 0 in the low bits

`endif

/* logic/regf_bus_pkg.sv */
//////////////////////////////////////////////////
// Register file host-side types
// APB request and response, and the single byte
// access passed from the completer to storage
//////////////////////////////////////////////////
`default_nettype none

`include "regf_settings.svh"

package regf_bus_pkg;

  // APB request from the host
  typedef struct packed
  {
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [`REGF_PADDR_W-1:0] paddr;
    logic [`REGF_DATA_W-1:0]  pwdata;
  } apb_req_t;

  // APB response to the host
  typedef struct packed
  {
    logic                     pready;
    logic                     pslverr;
    logic [`REGF_DATA_W-1:0]  prdata;
  } apb_rsp_t;

  // One byte access, rd and wr are single-cycle pulses
  typedef struct packed
  {
    logic                     rd;
    logic                     wr;
    logic [`REGF_ADDR_W-1:0]  addr;
    logic [`REGF_DATA_W-1:0]  wdata;
  } regf_acc_t;

endpackage

`default_nettype wire

/* logic/regf_desc_pkg.sv */
//////////////////////////////////////////////////
// Command descriptor and configuration types
// Two views of descriptor word 0, the decoded
// command and the controller config bundle
//////////////////////////////////////////////////
`default_nettype none

`include "regf_settings.svh"

package regf_desc_pkg;

  // Immediate form of word 0, attr[0] set
  typedef struct packed
  {
    logic       toc;        // Terminate on completion
    logic       wroc;       // Response on completion
    logic       rnw;
    logic [2:0] mode;
    logic [2:0] dtt;        // Data byte count of the immediate transfer
    logic [1:0] rsvd;
    logic [4:0] dev_index;
    logic       cp;         // CCC present
    logic [7:0] ccc;
    logic [3:0] tid;
    logic [2:0] attr;
  } desc_imm_t;

  // Regular form of word 0, attr[0] clear
  typedef struct packed
  {
    logic       toc;
    logic       wroc;
    logic       rnw;
    logic [2:0] mode;
    logic       dbp;        // Defining byte present
    logic       sre;        // Short read error
    logic [2:0] rsvd;
    logic [4:0] dev_index;
    logic       cp;
    logic [7:0] ccc;
    logic [3:0] tid;
    logic [2:0] attr;
  } desc_reg_t;

  typedef union packed
  {
    desc_imm_t imm;
    desc_reg_t regular;
  } desc_word0_u;

  // Decoded command, registered by the decoder
  typedef struct packed
  {
    logic [15:0] data_len;
    logic [2:0]  attr;
    logic [3:0]  tid;
    logic [7:0]  ccc;
    logic [4:0]  dev_index;
    logic [2:0]  dtt;
    logic [2:0]  mode;
    logic        rnw;
    logic        wroc;
    logic        toc;
    logic        cp;
    logic        dbp;
    logic        sre;
  } regf_cmd_t;

  // Configuration bundle for the rest of the controller
  typedef struct packed
  {
    logic [`REGF_DATA_W-1:0] num_frames;
    logic                    rx_tx;         // Target address bit 0
    logic [`REGF_DATA_W-1:0] ibi_cfg;
    logic [`REGF_DATA_W-1:0] payload_size;
    logic [`REGF_DATA_W-1:0] ibi_tgt_addr;  // Arbitration address
    logic [2:0]              hj_cfg;
    logic                    hj_support;
  } regf_cfg_t;

endpackage

`default_nettype wire

/* logic/regf_apb_slave.sv */
//////////////////////////////////////////////////
// APB completer for the register file
// One fixed wait state per transfer, issues a
// single byte access and returns the response
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "regf_settings.svh"

module regf_apb_slave
(
  input  wire                           i_regf_clk,
  input  wire                           i_regf_rst_n,
  input  wire regf_bus_pkg::apb_req_t   i_apb,
  output regf_bus_pkg::apb_rsp_t        o_apb,
  output regf_bus_pkg::regf_acc_t       o_acc,
  input  wire [`REGF_DATA_W-1:0]        i_rd_data     // Registered byte from storage
);

  logic access_q;   // Wait-state flag, high in the second access cycle
  logic err_q;      // Out-of-range transfer
  logic rd_q;       // A read was issued to storage
  logic start;      // First access cycle
  logic in_range;

  assign in_range = (i_apb.paddr < `REGF_PADDR_W'(`REGF_DEPTH));
  assign start    = i_apb.psel & i_apb.penable & ~access_q;

  // Access pulse, suppressed for an address outside the array
  always_comb
  begin
    o_acc.rd    = start & in_range & ~i_apb.pwrite;
    o_acc.wr    = start & in_range & i_apb.pwrite;
    o_acc.addr  = i_apb.paddr[`REGF_ADDR_W-1:0];
    o_acc.wdata = i_apb.pwdata;
  end

  //////////////////////////////////////////////////
  // Response registers
  //////////////////////////////////////////////////
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      access_q <= 1'b0;
      err_q    <= 1'b0;
      rd_q     <= 1'b0;
    end
    else
    begin
      access_q <= start;              // Clears itself once pready is seen
      err_q    <= start & ~in_range;
      rd_q     <= o_acc.rd;
    end
  end

  // Read data only shows for a completed in-range read
  always_comb
  begin
    o_apb.pready  = access_q;
    o_apb.pslverr = err_q;
    o_apb.prdata  = rd_q ? i_rd_data : '0;
  end

endmodule

`default_nettype wire

/* logic/regf_storage.sv */
//////////////////////////////////////////////////
// Register array of the I3C master
// Reset defaults, byte access, hot-join defining
// bits, descriptor window and config bundle
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "regf_settings.svh"

module regf_storage
(
  input  wire                                          i_regf_clk,
  input  wire                                          i_regf_rst_n,
  input  wire regf_bus_pkg::regf_acc_t                 i_acc,
  output logic [`REGF_DATA_W-1:0]                      o_rd_data,
  input  wire  [`REGF_ADDR_W-1:0]                      i_desc_addr,   // Descriptor base
  output logic [`REGF_DESC_BYTES-1:0][`REGF_DATA_W-1:0] o_desc_bytes,
  output regf_desc_pkg::regf_cfg_t                     o_cfg
);

  localparam logic [`REGF_DESC_BYTES*`REGF_DATA_W-1:0] DUMMY_DESC = `REGF_RST_DUMMY_DESC;

  logic [`REGF_DATA_W-1:0] mem [`REGF_DEPTH];
  logic                    hj_en;   // Hot-join supported and enabled

  // CRCAP1[0] supports hot-join, HJ_CFG[1] enables it
  assign hj_en = mem[`REGF_ADDR_CRCAP1][0] & mem[`REGF_ADDR_HJ_CFG][1];

  //////////////////////////////////////////////////
  // Array with defaults and hot-join rule
  //////////////////////////////////////////////////
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      for (int i = 0; i < `REGF_DEPTH; i++)
      begin
        mem[i] <= '0;
      end
      mem[`REGF_ADDR_TGT]          <= `REGF_RST_TGT;
      mem[`REGF_ADDR_NUM_FRAMES]   <= `REGF_RST_NUM_FRAMES;
      mem[`REGF_ADDR_TX_DATA]      <= `REGF_RST_TX_DATA0;
      mem[`REGF_ADDR_TX_DATA + 1]  <= `REGF_RST_TX_DATA1;
      mem[`REGF_ADDR_TX_DATA + 2]  <= `REGF_RST_TX_DATA2;
      mem[`REGF_ADDR_BCAST_WR]     <= `REGF_RST_BCAST_WR;
      mem[`REGF_ADDR_BCAST_RD]     <= `REGF_RST_BCAST_RD;
      mem[`REGF_ADDR_ARB]          <= `REGF_RST_ARB;
      mem[`REGF_ADDR_ENTDAA]       <= `REGF_RST_ENTDAA;
      // IBI and event control
      mem[`REGF_ADDR_IBI_CFG]      <= `REGF_RST_IBI_CFG;
      mem[`REGF_ADDR_PAYLOAD]      <= `REGF_RST_PAYLOAD;
      mem[`REGF_ADDR_DISEC_DIR]    <= `REGF_RST_DISEC_DIR;
      mem[`REGF_ADDR_DISEC_BC]     <= `REGF_RST_DISEC_BC;
      mem[`REGF_ADDR_EVT_DIS]      <= `REGF_RST_EVT_DIS;
      // Hot-join block
      mem[`REGF_ADDR_ENEC_CCC]     <= `REGF_RST_ENEC_CCC;
      mem[`REGF_ADDR_ENEC_BYTE]    <= `REGF_RST_ENEC_BYTE;
      mem[`REGF_ADDR_DISEC_CCC]    <= `REGF_RST_DISEC_CCC;
      mem[`REGF_ADDR_DISEC_BYTE]   <= `REGF_RST_DISEC_BYTE;
      mem[`REGF_ADDR_HJ_CFG]       <= `REGF_RST_HJ_CFG;
      mem[`REGF_ADDR_CRCAP1]       <= `REGF_RST_CRCAP1;
      // Dummy descriptor, a fixed command the engine can point at
      for (int d = 0; d < `REGF_DESC_BYTES; d++)
      begin
        mem[`REGF_ADDR_DUMMY_DESC + d] <= DUMMY_DESC[d*`REGF_DATA_W +: `REGF_DATA_W];
      end
    end
    else
    begin
      if (i_acc.wr)
      begin
        mem[i_acc.addr] <= i_acc.wdata;
      end
      // Defining bits follow the rule every cycle, overriding a host write
      mem[`REGF_ADDR_ENEC_BYTE][`REGF_HJ_BIT]  <= hj_en;    // ENHJ
      mem[`REGF_ADDR_DISEC_BYTE][`REGF_HJ_BIT] <= ~hj_en;   // DISHJ
    end
  end

  // Read port, holds the last byte read
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      o_rd_data <= '0;
    end
    else if (i_acc.rd)
    begin
      o_rd_data <= mem[i_acc.addr];
    end
  end

  //////////////////////////////////////////////////
  // Descriptor window, wraps at the array end
  //////////////////////////////////////////////////
  for (genvar b = 0; b < `REGF_DESC_BYTES; b++)
  begin : g_win
    assign o_desc_bytes[b] = mem[i_desc_addr + `REGF_ADDR_W'(b)];
  end

  // Configuration bundle, one cycle behind its source bytes
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      o_cfg <= '0;
    end
    else
    begin
      o_cfg.num_frames   <= mem[`REGF_ADDR_NUM_FRAMES];
      o_cfg.rx_tx        <= mem[`REGF_ADDR_TGT][0];
      o_cfg.ibi_cfg      <= mem[`REGF_ADDR_IBI_CFG];
      o_cfg.payload_size <= mem[`REGF_ADDR_PAYLOAD];
      o_cfg.ibi_tgt_addr <= mem[`REGF_ADDR_ARB];
      o_cfg.hj_cfg       <= mem[`REGF_ADDR_HJ_CFG][2:0];
      o_cfg.hj_support   <= mem[`REGF_ADDR_CRCAP1][0];
    end
  end

endmodule

`default_nettype wire

/* logic/regf_cmd_decoder.sv */
//////////////////////////////////////////////////
// Command descriptor decoder
// Builds the two descriptor words from the window
// and registers the immediate or regular fields
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "regf_settings.svh"

module regf_cmd_decoder
(
  input  wire                                          i_regf_clk,
  input  wire                                          i_regf_rst_n,
  input  wire [`REGF_DESC_BYTES-1:0][`REGF_DATA_W-1:0] i_desc_bytes,
  output regf_desc_pkg::regf_cmd_t                     o_cmd
);

  localparam int WORD_BYTES = `REGF_DESC_BYTES / 2;

  regf_desc_pkg::desc_word0_u             word0;
  logic [WORD_BYTES*`REGF_DATA_W-1:0]     word1;
  regf_desc_pkg::regf_cmd_t               cmd_d;

  // Byte 0 lands in the low bits of word 0
  assign word0 = i_desc_bytes[WORD_BYTES-1:0];
  assign word1 = i_desc_bytes[`REGF_DESC_BYTES-1:WORD_BYTES];

  //////////////////////////////////////////////////
  // Field decode
  //////////////////////////////////////////////////
  always_comb
  begin
    cmd_d.data_len  = word1[31:16];       // Frame count for the transfer
    cmd_d.attr      = word0.imm.attr;     // Shared fields sit alike in both views
    cmd_d.tid       = word0.imm.tid;
    cmd_d.ccc       = word0.imm.ccc;
    cmd_d.cp        = word0.imm.cp;
    cmd_d.dev_index = word0.imm.dev_index;
    cmd_d.mode      = word0.imm.mode;
    cmd_d.rnw       = word0.imm.rnw;
    cmd_d.wroc      = word0.imm.wroc;
    cmd_d.toc       = word0.imm.toc;
    if (word0.imm.attr[0])
    begin
      // Immediate
      cmd_d.dtt = word0.imm.dtt;
      cmd_d.dbp = 1'b0;
      cmd_d.sre = 1'b0;
    end
    else
    begin
      // Regular
      cmd_d.dtt = '0;
      cmd_d.dbp = word0.regular.dbp;
      cmd_d.sre = word0.regular.sre;
    end
  end

  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      o_cmd <= '0;
    end
    else
    begin
      o_cmd <= cmd_d;   // One cycle after the window moves
    end
  end

endmodule

`default_nettype wire

/* logic/regf_top.sv */
//////////////////////////////////////////////////
// I3C master register file top level
// APB completer, storage and descriptor decoder
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "regf_settings.svh"

module regf_top
(
  input  wire                           i_regf_clk,
  input  wire                           i_regf_rst_n,
  input  wire regf_bus_pkg::apb_req_t   i_apb,
  output regf_bus_pkg::apb_rsp_t        o_apb,
  input  wire [`REGF_ADDR_W-1:0]        i_desc_addr,    // Engine-selected descriptor base
  output regf_desc_pkg::regf_cmd_t      o_cmd,
  output regf_desc_pkg::regf_cfg_t      o_cfg
);

  regf_bus_pkg::regf_acc_t                        acc;
  logic [`REGF_DATA_W-1:0]                        rd_data;
  logic [`REGF_DESC_BYTES-1:0][`REGF_DATA_W-1:0]  desc_bytes;

  // Host side
  regf_apb_slave u_apb_slave
  (
    .i_regf_clk   (i_regf_clk),
    .i_regf_rst_n (i_regf_rst_n),
    .i_apb        (i_apb),
    .o_apb        (o_apb),
    .o_acc        (acc),
    .i_rd_data    (rd_data)
  );

  regf_storage u_storage
  (
    .i_regf_clk   (i_regf_clk),
    .i_regf_rst_n (i_regf_rst_n),
    .i_acc        (acc),
    .o_rd_data    (rd_data),
    .i_desc_addr  (i_desc_addr),
    .o_desc_bytes (desc_bytes),
    .o_cfg        (o_cfg)
  );

  // Engine side
  regf_cmd_decoder u_cmd_decoder
  (
    .i_regf_clk   (i_regf_clk),
    .i_regf_rst_n (i_regf_rst_n),
    .i_desc_bytes (desc_bytes),
    .o_cmd        (o_cmd)
  );

endmodule

`default_nettype wire

/* tests/regf_clk_gen.sv */
//////////////////////////////////////////////////
// Testbench clock generator
// Free-running clock with a 4 ns period
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module regf_clk_gen
(
  output logic o_clk
);

  localparam real HALF_PERIOD = 2.0;   // ns

  initial
  begin
    o_clk = 1'b0;                      // First rising edge at 2 ns
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

/* tests/regf_tb.sv */
//////////////////////////////////////////////////
// Register file testbench
// Random APB traffic against a byte model, with
// hot-join, descriptor decode and config checks
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "regf_settings.svh"

module regf_tb;

  localparam int SEED        = 95594;
  localparam int RAND_XFERS  = 300;
  localparam int ERR_ITERS   = 12;    // Two transfers each
  localparam int HJ_ITERS    = 16;    // Five transfers each
  localparam int DESC_ITERS  = 6;
  localparam int CFG_ITERS   = 8;     // Eight transfers each
  localparam int XFER_CYCLES = 3;     // Setup, access, access with pready
  localparam int TOTAL_XFERS = `REGF_DEPTH + RAND_XFERS + 2 * ERR_ITERS + 5 * HJ_ITERS
                               + DESC_ITERS * `REGF_DESC_BYTES + 8 * CFG_ITERS;
  localparam int MAX_CYCLES  = 3 * TOTAL_XFERS * XFER_CYCLES + 200;
  localparam logic [7:0] HJ_MASK = 8'(1 << `REGF_HJ_BIT);

  logic                       clk;
  logic                       rst_n;
  regf_bus_pkg::apb_req_t     apb_req;
  regf_bus_pkg::apb_rsp_t     apb_rsp;
  logic [`REGF_ADDR_W-1:0]    desc_addr;
  regf_desc_pkg::regf_cmd_t   cmd;
  regf_desc_pkg::regf_cfg_t   cfg;

  logic [`REGF_DATA_W-1:0]    model_mem [`REGF_DEPTH];  // Expected array contents
  int                         cycle_cnt = 0;
  logic [7:0]                 rdata;
  logic                       err;
  logic                       wr;
  logic [`REGF_ADDR_W-1:0]    addr;
  logic [`REGF_PADDR_W-1:0]   paddr;
  logic [7:0]                 wdata;
  logic [7:0]                 enec_wr;
  logic [7:0]                 disec_wr;
  logic                       hj_exp;
  logic [`REGF_ADDR_W-1:0]    base;
  logic [7:0]                 desc_byte;

  regf_clk_gen u_clk_gen
  (
    .o_clk (clk)
  );

  regf_top dut
  (
    .i_regf_clk   (clk),
    .i_regf_rst_n (rst_n),
    .i_apb        (apb_req),
    .o_apb        (apb_rsp),
    .i_desc_addr  (desc_addr),
    .o_cmd        (cmd),
    .o_cfg        (cfg)
  );

  //////////////////////////////////////////////////
  // Model and helpers
  //////////////////////////////////////////////////
  task automatic report_failure(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Checks failed");
    $fatal(1, "Stopped at the first failed check");
  endtask

  // ENHJ set and DISHJ clear only when supported and enabled
  task automatic apply_hot_join();
    logic hj;
    hj = model_mem[`REGF_ADDR_CRCAP1][0] & model_mem[`REGF_ADDR_HJ_CFG][1];
    model_mem[`REGF_ADDR_ENEC_BYTE][`REGF_HJ_BIT]  = hj;
    model_mem[`REGF_ADDR_DISEC_BYTE][`REGF_HJ_BIT] = !hj;
  endtask

  task automatic load_defaults();
    logic [63:0] dummy;
    dummy = `REGF_RST_DUMMY_DESC;
    for (int i = 0; i < `REGF_DEPTH; i++)
    begin
      model_mem[i] = '0;
    end
    model_mem[`REGF_ADDR_TGT]         = `REGF_RST_TGT;
    model_mem[`REGF_ADDR_NUM_FRAMES]  = `REGF_RST_NUM_FRAMES;
    model_mem[`REGF_ADDR_TX_DATA]     = `REGF_RST_TX_DATA0;
    model_mem[`REGF_ADDR_TX_DATA + 1] = `REGF_RST_TX_DATA1;
    model_mem[`REGF_ADDR_TX_DATA + 2] = `REGF_RST_TX_DATA2;
    model_mem[`REGF_ADDR_BCAST_WR]    = `REGF_RST_BCAST_WR;
    model_mem[`REGF_ADDR_BCAST_RD]    = `REGF_RST_BCAST_RD;
    model_mem[`REGF_ADDR_ARB]         = `REGF_RST_ARB;
    model_mem[`REGF_ADDR_ENTDAA]      = `REGF_RST_ENTDAA;
    model_mem[`REGF_ADDR_IBI_CFG]     = `REGF_RST_IBI_CFG;
    model_mem[`REGF_ADDR_PAYLOAD]     = `REGF_RST_PAYLOAD;
    model_mem[`REGF_ADDR_DISEC_DIR]   = `REGF_RST_DISEC_DIR;
    model_mem[`REGF_ADDR_DISEC_BC]    = `REGF_RST_DISEC_BC;
    model_mem[`REGF_ADDR_EVT_DIS]     = `REGF_RST_EVT_DIS;
    model_mem[`REGF_ADDR_ENEC_CCC]    = `REGF_RST_ENEC_CCC;
    model_mem[`REGF_ADDR_ENEC_BYTE]   = `REGF_RST_ENEC_BYTE;
    model_mem[`REGF_ADDR_DISEC_CCC]   = `REGF_RST_DISEC_CCC;
    model_mem[`REGF_ADDR_DISEC_BYTE]  = `REGF_RST_DISEC_BYTE;
    model_mem[`REGF_ADDR_HJ_CFG]      = `REGF_RST_HJ_CFG;
    model_mem[`REGF_ADDR_CRCAP1]      = `REGF_RST_CRCAP1;
    for (int d = 0; d < `REGF_DESC_BYTES; d++)
    begin
      model_mem[`REGF_ADDR_DUMMY_DESC + d] = dummy[d*8 +: 8];  // Byte 0 lowest
    end
  endtask

  // One APB transfer entered and left on a falling edge
  task automatic apb_transfer(input logic i_wr, input logic [`REGF_PADDR_W-1:0] i_addr,
                              input logic [7:0] i_wdata, output logic [7:0] o_rdata,
                              output logic o_err);
    int n_wait;
    apb_req.psel    = 1'b1;            // Setup
    apb_req.penable = 1'b0;
    apb_req.pwrite  = i_wr;
    apb_req.paddr   = i_addr;
    apb_req.pwdata  = i_wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;            // Access
    @(negedge clk);
    n_wait = 1;
    while (!apb_rsp.pready)
    begin
      @(negedge clk);
      n_wait++;
    end
    o_rdata = apb_rsp.prdata;
    o_err   = apb_rsp.pslverr;
    assert (n_wait == 1)
    else report_failure($sformatf("transfer to %0d took %0d access cycles", i_addr, n_wait + 1));
    @(negedge clk);                    // Past the completing edge
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic write_byte(input logic [`REGF_ADDR_W-1:0] a, input logic [7:0] d);
    logic [7:0] rd;
    logic       e;
    apb_transfer(1'b1, `REGF_PADDR_W'(a), d, rd, e);
    assert (!e)
    else report_failure($sformatf("write to %0d raised pslverr", a));
    model_mem[a] = d;
    apply_hot_join();
  endtask

  task automatic read_check(input logic [`REGF_ADDR_W-1:0] a, output logic [7:0] d);
    logic e;
    apb_transfer(1'b0, `REGF_PADDR_W'(a), 8'h00, d, e);
    assert (!e && d == model_mem[a])
    else report_failure($sformatf("read of %0d gave %h err %b, expected %h",
                                  a, d, e, model_mem[a]));
  endtask

  // Decode rule on the model bytes with the window wrapping at the depth
  function automatic regf_desc_pkg::regf_cmd_t expected_cmd(input logic [`REGF_ADDR_W-1:0] b);
    logic [31:0]              w0;
    logic [31:0]              w1;
    regf_desc_pkg::regf_cmd_t c;
    for (int i = 0; i < 4; i++)
    begin
      w0[i*8 +: 8] = model_mem[(int'(b) + i) % `REGF_DEPTH];
      w1[i*8 +: 8] = model_mem[(int'(b) + i + 4) % `REGF_DEPTH];
    end
    c           = '0;
    c.data_len  = w1[31:16];
    c.attr      = w0[2:0];
    c.tid       = w0[6:3];
    c.ccc       = w0[14:7];
    c.cp        = w0[15];
    c.dev_index = w0[20:16];
    c.mode      = w0[28:26];
    c.rnw       = w0[29];
    c.wroc      = w0[30];
    c.toc       = w0[31];
    if (w0[0])
    begin
      c.dtt = w0[25:23];               // Immediate
    end
    else
    begin
      c.dbp = w0[25];                  // Regular
      c.sre = w0[24];
    end
    return c;
  endfunction

  function automatic regf_desc_pkg::regf_cfg_t expected_cfg();
    regf_desc_pkg::regf_cfg_t c;
    c.num_frames   = model_mem[`REGF_ADDR_NUM_FRAMES];
    c.rx_tx        = model_mem[`REGF_ADDR_TGT][0];
    c.ibi_cfg      = model_mem[`REGF_ADDR_IBI_CFG];
    c.payload_size = model_mem[`REGF_ADDR_PAYLOAD];
    c.ibi_tgt_addr = model_mem[`REGF_ADDR_ARB];
    c.hj_cfg       = model_mem[`REGF_ADDR_HJ_CFG][2:0];
    c.hj_support   = model_mem[`REGF_ADDR_CRCAP1][0];
    return c;
  endfunction

  task automatic check_desc(input logic [`REGF_ADDR_W-1:0] b);
    regf_desc_pkg::regf_cmd_t exp;
    desc_addr = b;
    repeat (2) @(negedge clk);         // Window is registered once by the decoder
    exp = expected_cmd(b);
    assert (cmd == exp)
    else report_failure($sformatf("descriptor at %0d decoded %h, expected %h", b, cmd, exp));
  endtask

  // Run limit
  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > MAX_CYCLES)
    begin
      $display("Run stopped, cycle limit of %0d reached before the tests finished", MAX_CYCLES);
      $display("Checks failed");
      $fatal(1, "Cycle limit reached");
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial
  begin
    apb_req   = '0;
    desc_addr = '0;
    rst_n     = 1'b0;
    void'($urandom(SEED));
    load_defaults();
    repeat (3) @(negedge clk);

    // Reset state checked just before release
    assert (cmd == '0 && cfg == '0 && apb_rsp == '0)
    else report_failure($sformatf("outputs not zero in reset: cmd %h cfg %h", cmd, cfg));
    rst_n = 1'b1;
    apply_hot_join();                  // Rule acts from the first clock
    for (int a = 0; a < `REGF_DEPTH; a++)
    begin
      read_check(`REGF_ADDR_W'(a), rdata);
    end

    // Random traffic
    for (int n = 0; n < RAND_XFERS; n++)
    begin
      addr = `REGF_ADDR_W'($urandom_range(`REGF_DEPTH - 1, 0));
      if ($urandom_range(1, 0) == 1)
        write_byte(addr, 8'($urandom));
      else
        read_check(addr, rdata);
    end

    // Out-of-range transfers
    for (int n = 0; n < ERR_ITERS; n++)
    begin
      paddr = `REGF_PADDR_W'($urandom_range((1 << `REGF_PADDR_W) - 1, `REGF_DEPTH));
      wr    = 1'($urandom_range(1, 0));
      wdata = 8'($urandom);
      apb_transfer(wr, paddr, wdata, rdata, err);
      assert (err && rdata == 8'h00)
      else report_failure($sformatf("address %0d gave err %b data %h", paddr, err, rdata));
      read_check(paddr[`REGF_ADDR_W-1:0], rdata);   // Aliased byte untouched
    end

    // Hot-join defining bits
    for (int n = 0; n < HJ_ITERS; n++)
    begin
      enec_wr  = 8'($urandom);
      disec_wr = 8'($urandom);
      write_byte(`REGF_ADDR_ENEC_BYTE, enec_wr);
      write_byte(`REGF_ADDR_DISEC_BYTE, disec_wr);
      if ($urandom_range(1, 0) == 1)
        write_byte(`REGF_ADDR_HJ_CFG, 8'($urandom));
      else
        write_byte(`REGF_ADDR_CRCAP1, 8'($urandom));
      hj_exp = model_mem[`REGF_ADDR_CRCAP1][0] & model_mem[`REGF_ADDR_HJ_CFG][1];
      read_check(`REGF_ADDR_ENEC_BYTE, rdata);
      assert (rdata[`REGF_HJ_BIT] == hj_exp && (rdata & ~HJ_MASK) == (enec_wr & ~HJ_MASK))
      else report_failure($sformatf("ENEC byte %h after write %h, ENHJ %b",
                                    rdata, enec_wr, hj_exp));
      read_check(`REGF_ADDR_DISEC_BYTE, rdata);
      assert (rdata[`REGF_HJ_BIT] == !hj_exp && (rdata & ~HJ_MASK) == (disec_wr & ~HJ_MASK))
      else report_failure($sformatf("DISEC byte %h after write %h", rdata, disec_wr));
    end

    // Descriptors alternate between regular and immediate
    for (int n = 0; n < DESC_ITERS; n++)
    begin
      base = `REGF_ADDR_W'($urandom_range(`REGF_DEPTH - 1, 0));
      for (int i = 0; i < `REGF_DESC_BYTES; i++)
      begin
        desc_byte = 8'($urandom);
        if (i == 0)
          desc_byte[0] = n[0];         // attr[0] selects the form
        write_byte(base + `REGF_ADDR_W'(i), desc_byte);
      end
      check_desc(base);
    end
    check_desc(`REGF_ADDR_DUMMY_DESC);

    // Configuration bundle
    for (int n = 0; n < CFG_ITERS; n++)
    begin
      write_byte(`REGF_ADDR_NUM_FRAMES, 8'($urandom));
      write_byte(`REGF_ADDR_TGT, 8'($urandom));
      write_byte(`REGF_ADDR_IBI_CFG, 8'($urandom));
      write_byte(`REGF_ADDR_PAYLOAD, 8'($urandom));
      write_byte(`REGF_ADDR_ARB, 8'($urandom));
      write_byte(`REGF_ADDR_HJ_CFG, 8'($urandom));
      write_byte(`REGF_ADDR_CRCAP1, 8'($urandom));
      read_check(`REGF_ADDR_W'($urandom_range(`REGF_DEPTH - 1, 0)), rdata);
      assert (cfg == expected_cfg())
      else report_failure($sformatf("config bundle %h, expected %h", cfg, expected_cfg()));
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* regf.f */
+incdir+logic
logic/regf_bus_pkg.sv
logic/regf_desc_pkg.sv
logic/regf_apb_slave.sv
logic/regf_storage.sv
logic/regf_cmd_decoder.sv
logic/regf_top.sv
tests/regf_clk_gen.sv
tests/regf_tb.sv
